// File: verilog/bist_settings.svh
// array geometry, data widths and pattern depths for the hybrid BIST controller
`ifndef BIST_SETTINGS_SVH
`define BIST_SETTINGS_SVH

// systolic array geometry, one accumulator row per lane
`define BIST_ARRAY_SIZE 8

// data word widths
`define BIST_WEIGHT_W 8
`define BIST_ACT_W 8
`define BIST_PSUM_W 19 // weight + activation + log2(size)

// accumulator address width
`define BIST_ADDR_W 3

// pattern tables
`define BIST_MBIST_DEPTH 8 // memory backgrounds
`define BIST_SA_DEPTH 12 // stuck-at patterns held in eNVM
`define BIST_PAT_W 4 // wide enough for the larger table

`endif

// File: verilog/bist_ctrl_pkg.sv
// controller state and mode enums
// command and status structs between the FSM, sequencer and comparator
`include "bist_settings.svh"

package bist_ctrl_pkg;

    typedef enum logic [4:0] {
        idle,
        mbist_write,
        mbist_read,
        mbist_check,
        sa_shift,
        sa_capture,
        sa_check,
        done_pass,
        done_fail
    } bist_state_e;

    typedef enum logic {
        mode_mbist = 1'b0,
        mode_lbist = 1'b1
    } bist_mode_e;

    // fsm to sequencer
    typedef struct packed {
        logic clear;
        logic step_addr;
        logic step_pattern;
    } seq_cmd_t;

    // sequencer to fsm
    typedef struct packed {
        logic [`BIST_ADDR_W-1:0] addr;
        logic [`BIST_PAT_W-1:0] pattern;
        logic addr_last; // addr at top of range
        logic pattern_last; // last pattern of current mode
    } seq_status_t;

    // fsm to comparator
    typedef struct packed {
        logic load_mbist;
        logic load_envm;
        logic check;
        logic clear_fail;
    } cmp_ctrl_t;

endpackage

// File: verilog/array_data_pkg.sv
// data word types, lane vectors and the accumulator port
// shared by the controller and the array side
`include "bist_settings.svh"

package array_data_pkg;

    typedef logic [`BIST_WEIGHT_W-1:0] weight_t;
    typedef logic [`BIST_ACT_W-1:0] act_t;
    typedef logic [`BIST_PSUM_W-1:0] psum_t;

    // one partial sum per lane
    typedef psum_t [`BIST_ARRAY_SIZE-1:0] lane_psum_t;

    // one flag per lane
    typedef logic [`BIST_ARRAY_SIZE-1:0] lane_mask_t;

    // broadcast test vector, valid while scan_en is high
    typedef struct packed {
        weight_t [`BIST_ARRAY_SIZE-1:0] weight;
        act_t [`BIST_ARRAY_SIZE-1:0] act;
        lane_psum_t psum;
    } test_vec_t;

    // accumulator memory port, read data returns one cycle after rd_addr
    typedef struct packed {
        logic wr_en;
        logic [`BIST_ADDR_W-1:0] wr_addr;
        lane_psum_t wr_data;
        logic [`BIST_ADDR_W-1:0] rd_addr;
    } acc_port_t;

endpackage

// File: verilog/bist_fsm.sv
// test state machine for memory and stuck-at BIST
// drives sequencer commands, comparator strobes and result outputs
`timescale 1ns/1ps

module bist_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  bist_ctrl_pkg::bist_mode_e bist_mode,
    input  bist_ctrl_pkg::seq_status_t seq_status,
    input  logic mismatch_any,
    output bist_ctrl_pkg::seq_cmd_t seq_cmd,
    output bist_ctrl_pkg::cmp_ctrl_t cmp_ctrl,
    output logic acc_wr_en,
    output logic acc_rd_addr, // 1 reads at sequencer addr, 0 reads slot 0
    output logic scan_en,
    output logic test_done,
    output logic mbist_result,
    output logic lbist_result
);

    bist_ctrl_pkg::bist_state_e state, next_state;
    bist_ctrl_pkg::bist_mode_e mode_q; // mode of the running test

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= bist_ctrl_pkg::idle;
            mode_q <= bist_ctrl_pkg::mode_mbist;
        end else begin
            state <= next_state;
            if (state == bist_ctrl_pkg::idle && start) begin
                mode_q <= bist_mode;
            end
        end
    end

    always_comb begin
        next_state = state;
        seq_cmd = '0;
        cmp_ctrl = '0;
        acc_wr_en = 1'b0;
        acc_rd_addr = 1'b0;
        scan_en = 1'b0;
        case (state)
            bist_ctrl_pkg::idle: begin
                if (start) begin
                    seq_cmd.clear = 1'b1;
                    cmp_ctrl.clear_fail = 1'b1;
                    next_state = (bist_mode == bist_ctrl_pkg::mode_lbist) ?
                                 bist_ctrl_pkg::sa_shift : bist_ctrl_pkg::mbist_write;
                end
            end
            // fill all addresses with the current background
            bist_ctrl_pkg::mbist_write: begin
                acc_wr_en = 1'b1;
                seq_cmd.step_addr = 1'b1;
                if (seq_status.addr_last) begin
                    next_state = bist_ctrl_pkg::mbist_read; // addr wraps to 0
                end
            end
            bist_ctrl_pkg::mbist_read: begin
                acc_rd_addr = 1'b1;
                cmp_ctrl.load_mbist = 1'b1;
                next_state = bist_ctrl_pkg::mbist_check;
            end
            bist_ctrl_pkg::mbist_check: begin
                acc_rd_addr = 1'b1;
                cmp_ctrl.check = 1'b1;
                if (mismatch_any) begin
                    next_state = bist_ctrl_pkg::done_fail;
                end else if (seq_status.addr_last && seq_status.pattern_last) begin
                    next_state = bist_ctrl_pkg::done_pass;
                end else begin
                    seq_cmd.step_addr = 1'b1;
                    if (seq_status.addr_last) begin
                        seq_cmd.step_pattern = 1'b1; // next background
                        next_state = bist_ctrl_pkg::mbist_write;
                    end else begin
                        next_state = bist_ctrl_pkg::mbist_read;
                    end
                end
            end
            bist_ctrl_pkg::sa_shift: begin
                scan_en = 1'b1;
                cmp_ctrl.load_envm = 1'b1; // expected answer for this pattern
                next_state = bist_ctrl_pkg::sa_capture;
            end
            bist_ctrl_pkg::sa_capture: begin
                next_state = bist_ctrl_pkg::sa_check; // array result settles
            end
            bist_ctrl_pkg::sa_check: begin
                cmp_ctrl.check = 1'b1;
                if (mismatch_any) begin
                    next_state = bist_ctrl_pkg::done_fail;
                end else if (seq_status.pattern_last) begin
                    next_state = bist_ctrl_pkg::done_pass;
                end else begin
                    seq_cmd.step_pattern = 1'b1;
                    next_state = bist_ctrl_pkg::sa_shift;
                end
            end
            bist_ctrl_pkg::done_pass, bist_ctrl_pkg::done_fail: begin
                if (!start) begin
                    next_state = bist_ctrl_pkg::idle; // host released start
                end
            end
            default: next_state = bist_ctrl_pkg::idle;
        endcase
    end

    // results held for as long as the done state lasts
    assign test_done = (state == bist_ctrl_pkg::done_pass) ||
                       (state == bist_ctrl_pkg::done_fail);
    assign mbist_result = (state == bist_ctrl_pkg::done_pass) &&
                          (mode_q == bist_ctrl_pkg::mode_mbist);
    assign lbist_result = (state == bist_ctrl_pkg::done_pass) &&
                          (mode_q == bist_ctrl_pkg::mode_lbist);

endmodule

// File: verilog/bist_sequencer.sv
// address and pattern counters with end-of-range flags
`timescale 1ns/1ps
`include "bist_settings.svh"

module bist_sequencer (
    input  logic clk,
    input  logic rst_n,
    input  bist_ctrl_pkg::bist_mode_e bist_mode,
    input  bist_ctrl_pkg::seq_cmd_t seq_cmd,
    output bist_ctrl_pkg::seq_status_t seq_status
);

    logic [`BIST_ADDR_W-1:0] addr;
    logic [`BIST_PAT_W-1:0] pattern;
    logic [`BIST_PAT_W-1:0] pattern_max;
    logic addr_last;

    assign addr_last = (addr == `BIST_ADDR_W'(`BIST_ARRAY_SIZE - 1));

    // table depth depends on the test being run
    assign pattern_max = (bist_mode == bist_ctrl_pkg::mode_lbist) ?
                         `BIST_PAT_W'(`BIST_SA_DEPTH - 1) :
                         `BIST_PAT_W'(`BIST_MBIST_DEPTH - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr <= '0;
            pattern <= '0;
        end else if (seq_cmd.clear) begin
            addr <= '0;
            pattern <= '0;
        end else begin
            if (seq_cmd.step_addr) begin
                addr <= addr_last ? '0 : addr + 1'b1; // wrap at last row
            end
            if (seq_cmd.step_pattern) begin
                pattern <= pattern + 1'b1;
            end
        end
    end

    always_comb begin
        seq_status.addr = addr;
        seq_status.pattern = pattern;
        seq_status.addr_last = addr_last;
        seq_status.pattern_last = (pattern == pattern_max);
    end

endmodule

// File: verilog/mbist_pattern_gen.sv
// memory test background table, one word per pattern index
`timescale 1ns/1ps
`include "bist_settings.svh"

module mbist_pattern_gen (
    input  logic [$clog2(`BIST_MBIST_DEPTH)-1:0] pattern,
    output array_data_pkg::psum_t mbist_word
);

    array_data_pkg::psum_t checker_word; // 0101... with lsb set
    array_data_pkg::psum_t low_word; // lower ten bits set

    assign checker_word = array_data_pkg::psum_t'({`BIST_PSUM_W{2'b01}});
    assign low_word = array_data_pkg::psum_t'(10'h3ff);

    always_comb begin
        case (pattern)
            3'd0: mbist_word = '0;
            3'd1: mbist_word = '1;
            3'd2: mbist_word = checker_word;
            3'd3: mbist_word = ~checker_word;
            3'd4: mbist_word = low_word;
            3'd5: mbist_word = ~low_word; // upper nine bits
            3'd6: mbist_word = array_data_pkg::psum_t'(1);
            default: mbist_word = array_data_pkg::psum_t'(1) << (`BIST_PSUM_W - 1); // msb only
        endcase
    end

endmodule

// File: verilog/result_comparator.sv
// expected-value register, per-lane compare and sticky fail mask
`timescale 1ns/1ps

module result_comparator (
    input  logic clk,
    input  logic rst_n,
    input  bist_ctrl_pkg::cmp_ctrl_t cmp_ctrl,
    input  array_data_pkg::psum_t mbist_word,
    input  array_data_pkg::psum_t envm_answer,
    input  array_data_pkg::lane_psum_t acc_rd_data,
    output logic mismatch_any,
    output array_data_pkg::lane_mask_t fail_lanes
);

    array_data_pkg::psum_t expected;
    array_data_pkg::lane_mask_t lane_diff;

    // background in mbist_read, eNVM answer in sa_shift
    always_ff @(posedge clk) begin
        if (cmp_ctrl.load_mbist) begin
            expected <= mbist_word;
        end else if (cmp_ctrl.load_envm) begin
            expected <= envm_answer;
        end
    end

    always_comb begin
        for (int i = 0; i < $bits(array_data_pkg::lane_mask_t); i++) begin
            lane_diff[i] = cmp_ctrl.check && (acc_rd_data[i] != expected);
        end
    end

    assign mismatch_any = |lane_diff;

    // sticky until the next start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fail_lanes <= '0;
        end else if (cmp_ctrl.clear_fail) begin
            fail_lanes <= '0;
        end else if (cmp_ctrl.check) begin
            fail_lanes <= fail_lanes | lane_diff;
        end
    end

endmodule

// File: verilog/hybrid_bist.sv
// hybrid BIST top for accumulator memory and PE array
// wires FSM, sequencer, background table and comparator
`timescale 1ns/1ps
`include "bist_settings.svh"

module hybrid_bist (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  bist_ctrl_pkg::bist_mode_e bist_mode,
    input  array_data_pkg::weight_t envm_weight,
    input  array_data_pkg::act_t envm_activation,
    input  array_data_pkg::psum_t envm_psum_in,
    input  array_data_pkg::psum_t envm_answer,
    input  array_data_pkg::lane_psum_t acc_rd_data,
    output logic [`BIST_PAT_W-1:0] test_counter, // eNVM pattern index
    output logic scan_en,
    output array_data_pkg::test_vec_t test_vec,
    output array_data_pkg::acc_port_t acc,
    output logic test_done,
    output logic mbist_result,
    output logic lbist_result,
    output array_data_pkg::lane_mask_t fail_lanes
);

    bist_ctrl_pkg::seq_cmd_t seq_cmd;
    bist_ctrl_pkg::seq_status_t seq_status;
    bist_ctrl_pkg::cmp_ctrl_t cmp_ctrl;
    array_data_pkg::psum_t mbist_word;
    logic mismatch_any;
    logic acc_wr_en;
    logic acc_rd_sel;

    bist_fsm bist_fsm_inst (
        .clk(clk),
        .rst_n(rst_n),
        .start(start),
        .bist_mode(bist_mode),
        .seq_status(seq_status),
        .mismatch_any(mismatch_any),
        .seq_cmd(seq_cmd),
        .cmp_ctrl(cmp_ctrl),
        .acc_wr_en(acc_wr_en),
        .acc_rd_addr(acc_rd_sel),
        .scan_en(scan_en),
        .test_done(test_done),
        .mbist_result(mbist_result),
        .lbist_result(lbist_result)
    );

    bist_sequencer bist_sequencer_inst (
        .clk(clk),
        .rst_n(rst_n),
        .bist_mode(bist_mode),
        .seq_cmd(seq_cmd),
        .seq_status(seq_status)
    );

    mbist_pattern_gen mbist_pattern_gen_inst (
        .pattern(seq_status.pattern[$clog2(`BIST_MBIST_DEPTH)-1:0]),
        .mbist_word(mbist_word)
    );

    result_comparator result_comparator_inst (
        .clk(clk),
        .rst_n(rst_n),
        .cmp_ctrl(cmp_ctrl),
        .mbist_word(mbist_word),
        .envm_answer(envm_answer),
        .acc_rd_data(acc_rd_data),
        .mismatch_any(mismatch_any),
        .fail_lanes(fail_lanes)
    );

    assign test_counter = seq_status.pattern;

    // same eNVM words and background broadcast to every lane
    always_comb begin
        for (int i = 0; i < `BIST_ARRAY_SIZE; i++) begin
            test_vec.weight[i] = envm_weight;
            test_vec.act[i] = envm_activation;
            test_vec.psum[i] = envm_psum_in;
            acc.wr_data[i] = mbist_word;
        end
        acc.wr_en = acc_wr_en;
        acc.wr_addr = seq_status.addr;
        acc.rd_addr = acc_rd_sel ? seq_status.addr : '0; // slot 0 holds array result
    end

endmodule

// File: test/tb_clock_gen.sv
// free-running testbench clock, 4 ns period
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    localparam real HALF_PERIOD_NS = 2.0;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

// File: test/hybrid_bist_checker.sv
// concurrent assertions on the hybrid BIST outputs, bound to the top level
`timescale 1ns/1ps

module hybrid_bist_checker (
    input logic clk,
    input logic rst_n,
    input logic scan_en,
    input array_data_pkg::acc_port_t acc,
    input logic test_done,
    input logic mbist_result,
    input logic lbist_result,
    input array_data_pkg::lane_mask_t fail_lanes
);

    // array broadcast and memory writes share the accumulator
    a_no_scan_during_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(scan_en && acc.wr_en))
        else $error("scan_en and accumulator write enable high in the same cycle");

    // pass in one mode, or fail with both results low
    a_one_outcome: assert property (@(posedge clk) disable iff (!rst_n)
        test_done |-> $onehot0({mbist_result, lbist_result}))
        else $error("both result flags high while test_done is set");

    a_result_needs_done: assert property (@(posedge clk) disable iff (!rst_n)
        (mbist_result || lbist_result) |-> test_done)
        else $error("result flag high without test_done");

    a_quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (!scan_en && !acc.wr_en && !test_done && !mbist_result
                          && !lbist_result && (fail_lanes == '0)))
        else $error("outputs not idle on the first cycle out of reset");

endmodule

// File: test/tb_hybrid_bist.sv
// testbench for the hybrid BIST controller
// accumulator, array and eNVM models, reference outcome, compare tasks, watchdog
`timescale 1ns/1ps
`include "bist_settings.svh"

module tb_hybrid_bist;

    localparam int CLK_PERIOD_NS = 4;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS = 5;
    localparam int MAX_TEST_CYCLES = 250;
    localparam int WATCHDOG_NS = CLK_PERIOD_NS * NUM_TESTS * MAX_TEST_CYCLES * 2;
    localparam int LANES = `BIST_ARRAY_SIZE;

    typedef struct packed {
        logic pass;
        array_data_pkg::lane_mask_t mask;
        logic [7:0] units; // backgrounds written or patterns shifted
    } outcome_t;

    logic clk;
    logic rst_n;
    logic start;
    bist_ctrl_pkg::bist_mode_e bist_mode;
    array_data_pkg::weight_t envm_weight;
    array_data_pkg::act_t envm_activation;
    array_data_pkg::psum_t envm_psum_in;
    array_data_pkg::psum_t envm_answer;
    array_data_pkg::lane_psum_t acc_rd_data;
    logic [`BIST_PAT_W-1:0] test_counter;
    logic scan_en;
    array_data_pkg::test_vec_t test_vec;
    array_data_pkg::acc_port_t acc;
    logic test_done;
    logic mbist_result;
    logic lbist_result;
    array_data_pkg::lane_mask_t fail_lanes;

    // models
    array_data_pkg::lane_psum_t mem [`BIST_ARRAY_SIZE];
    array_data_pkg::lane_psum_t mem_rd_q;
    array_data_pkg::lane_psum_t array_q;
    array_data_pkg::weight_t envm_w_tab [`BIST_SA_DEPTH];
    array_data_pkg::act_t envm_a_tab [`BIST_SA_DEPTH];
    array_data_pkg::psum_t envm_p_tab [`BIST_SA_DEPTH];
    array_data_pkg::psum_t envm_ans_tab [`BIST_SA_DEPTH];

    // stuck-at-one fault injection
    logic mem_fault_en;
    int mem_fault_lane;
    int mem_fault_bit;
    logic arr_fault_en;
    int arr_fault_lane;
    int arr_fault_bit;

    int check_count = 0;
    int error_count = 0;
    int test_index = 0;
    int write_count = 0;
    int scan_count = 0;

    // request to the compare process
    logic cmp_req = 1'b0;
    outcome_t cmp_exp;
    bist_ctrl_pkg::bist_mode_e cmp_mode;
    int cmp_cycles;
    int cmp_limit;

    tb_clock_gen clock_gen_inst (.clk(clk));

    hybrid_bist hybrid_bist_inst (
        .clk(clk),
        .rst_n(rst_n),
        .start(start),
        .bist_mode(bist_mode),
        .envm_weight(envm_weight),
        .envm_activation(envm_activation),
        .envm_psum_in(envm_psum_in),
        .envm_answer(envm_answer),
        .acc_rd_data(acc_rd_data),
        .test_counter(test_counter),
        .scan_en(scan_en),
        .test_vec(test_vec),
        .acc(acc),
        .test_done(test_done),
        .mbist_result(mbist_result),
        .lbist_result(lbist_result),
        .fail_lanes(fail_lanes)
    );

    bind hybrid_bist hybrid_bist_checker hybrid_bist_checker_inst (
        .clk(clk),
        .rst_n(rst_n),
        .scan_en(scan_en),
        .acc(acc),
        .test_done(test_done),
        .mbist_result(mbist_result),
        .lbist_result(lbist_result),
        .fail_lanes(fail_lanes)
    );

    function automatic array_data_pkg::psum_t stuck_bits(input logic en, input int sel_lane,
                                                         input int sel_bit, input int lane);
        if (en && (lane == sel_lane)) begin
            return array_data_pkg::psum_t'(1) << sel_bit;
        end
        return '0;
    endfunction

    // PE rule, weight times activation plus partial sum
    function automatic array_data_pkg::psum_t mac(input array_data_pkg::weight_t w,
                                                  input array_data_pkg::act_t a,
                                                  input array_data_pkg::psum_t p);
        return array_data_pkg::psum_t'(w) * array_data_pkg::psum_t'(a) + p;
    endfunction

    // memory backgrounds built bit by bit
    function automatic array_data_pkg::psum_t background(input int idx);
        array_data_pkg::psum_t word;
        word = '0;
        for (int b = 0; b < `BIST_PSUM_W; b++) begin
            case (idx)
                0: word[b] = 1'b0;
                1: word[b] = 1'b1;
                2: word[b] = (b % 2 == 0);
                3: word[b] = (b % 2 == 1);
                4: word[b] = (b < 10);
                5: word[b] = (b >= 10);
                6: word[b] = (b == 0);
                default: word[b] = (b == `BIST_PSUM_W - 1);
            endcase
        end
        return word;
    endfunction

    // expected pass flag, fail mask and units run, stopping at the first bad step
    function automatic outcome_t reference_outcome(input bist_ctrl_pkg::bist_mode_e mode);
        outcome_t res;
        array_data_pkg::psum_t got;
        array_data_pkg::psum_t want;
        int depth;
        res = '0;
        res.pass = 1'b1;
        depth = (mode == bist_ctrl_pkg::mode_lbist) ? `BIST_SA_DEPTH : `BIST_MBIST_DEPTH;
        for (int p = 0; p < depth; p++) begin
            res.units = 8'(p + 1);
            for (int i = 0; i < LANES; i++) begin
                if (mode == bist_ctrl_pkg::mode_lbist) begin
                    want = envm_ans_tab[p];
                    got = mac(envm_w_tab[p], envm_a_tab[p], envm_p_tab[p])
                          | stuck_bits(arr_fault_en, arr_fault_lane, arr_fault_bit, i);
                end else begin
                    want = background(p);
                    got = want | stuck_bits(mem_fault_en, mem_fault_lane, mem_fault_bit, i);
                end
                if (got != want) begin
                    res.mask[i] = 1'b1;
                end
            end
            if (res.mask != '0) begin
                res.pass = 1'b0;
                return res;
            end
        end
        return res;
    endfunction

    task automatic check_result(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_mask(input string what, input array_data_pkg::lane_mask_t got,
                              input array_data_pkg::lane_mask_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input string what, input array_data_pkg::psum_t got,
                              input array_data_pkg::psum_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
        end
    endtask

    // accumulator, one-cycle read latency
    always @(posedge clk) begin
        if (acc.wr_en) begin
            for (int i = 0; i < LANES; i++) begin
                mem[acc.wr_addr][i] <= acc.wr_data[i]
                    | stuck_bits(mem_fault_en, mem_fault_lane, mem_fault_bit, i);
            end
        end
        mem_rd_q <= mem[acc.rd_addr];
    end

    // PE array latches on scan_en
    always @(posedge clk) begin
        if (scan_en) begin
            for (int i = 0; i < LANES; i++) begin
                array_q[i] <= mac(test_vec.weight[i], test_vec.act[i], test_vec.psum[i])
                    | stuck_bits(arr_fault_en, arr_fault_lane, arr_fault_bit, i);
            end
        end
    end

    assign acc_rd_data = (bist_mode == bist_ctrl_pkg::mode_lbist) ? array_q : mem_rd_q;

    // eNVM answers combinationally
    assign envm_weight = (test_counter < `BIST_SA_DEPTH) ? envm_w_tab[test_counter] : '0;
    assign envm_activation = (test_counter < `BIST_SA_DEPTH) ? envm_a_tab[test_counter] : '0;
    assign envm_psum_in = (test_counter < `BIST_SA_DEPTH) ? envm_p_tab[test_counter] : '0;
    assign envm_answer = (test_counter < `BIST_SA_DEPTH) ? envm_ans_tab[test_counter] : '0;

    // write data and eNVM index order, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && acc.wr_en) begin
            check_word("write address", array_data_pkg::psum_t'(acc.wr_addr),
                       array_data_pkg::psum_t'(write_count % LANES));
            for (int i = 0; i < LANES; i++) begin
                check_word("write data", acc.wr_data[i], background(write_count / LANES));
            end
            write_count++;
        end
        if (rst_n && scan_en) begin
            check_word("eNVM index", array_data_pkg::psum_t'(test_counter),
                       array_data_pkg::psum_t'(scan_count));
            scan_count++;
        end
    end

    // compares the finished run against the reference
    initial begin
        forever begin
            wait (cmp_req);
            check_result("mbist_result", mbist_result,
                         (cmp_mode == bist_ctrl_pkg::mode_mbist) && cmp_exp.pass);
            check_result("lbist_result", lbist_result,
                         (cmp_mode == bist_ctrl_pkg::mode_lbist) && cmp_exp.pass);
            check_mask("fail_lanes", fail_lanes, cmp_exp.mask);
            if (cmp_mode == bist_ctrl_pkg::mode_mbist) begin
                check_word("writes issued", array_data_pkg::psum_t'(write_count),
                           array_data_pkg::psum_t'(cmp_exp.units * LANES));
                check_word("scan cycles", array_data_pkg::psum_t'(scan_count), '0);
            end else begin
                check_word("scan cycles", array_data_pkg::psum_t'(scan_count),
                           array_data_pkg::psum_t'(cmp_exp.units));
                check_word("writes issued", array_data_pkg::psum_t'(write_count), '0);
            end
            if (cmp_exp.pass && (cmp_cycles > cmp_limit)) begin
                error_count++;
                $display("run took %0d cycles to finish, more than the %0d allowed",
                         cmp_cycles, cmp_limit);
            end
            cmp_req = 1'b0;
        end
    end

    task automatic run_test(input string name, input bist_ctrl_pkg::bist_mode_e mode,
                            input int limit);
        outcome_t exp;
        int cycles;
        int errors_before;
        errors_before = error_count;
        test_index++;
        exp = reference_outcome(mode);
        write_count = 0;
        scan_count = 0;
        cycles = 0;
        @(negedge clk);
        bist_mode = mode;
        start = 1'b1;
        do begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            if (cycles == 1) begin
                check_mask("fail_lanes at start", fail_lanes, '0);
            end
        end while (!test_done && (cycles < MAX_TEST_CYCLES));
        if (!test_done) begin
            error_count++;
            $display("%s: test_done never rose within %0d cycles", name, MAX_TEST_CYCLES);
        end else begin
            cmp_exp = exp;
            cmp_mode = mode;
            cmp_cycles = cycles;
            cmp_limit = limit;
            cmp_req = 1'b1;
            wait (!cmp_req);
        end
        // done holds while start stays high
        @(posedge clk);
        @(negedge clk);
        check_result("test_done held", test_done, 1'b1);
        start = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_result("test_done after release", test_done, 1'b0);
        check_result("mbist_result after release", mbist_result, 1'b0);
        check_result("lbist_result after release", lbist_result, 1'b0);
        $display("[%0d] %-20s %0d cycles, %0d errors", test_index, name, cycles,
                 error_count - errors_before);
    endtask

    initial begin
        void'($urandom(75));
        rst_n = 1'b0;
        start = 1'b0;
        bist_mode = bist_ctrl_pkg::mode_mbist;
        mem_fault_en = 1'b0;
        mem_fault_lane = 0;
        mem_fault_bit = 0;
        arr_fault_en = 1'b0;
        arr_fault_lane = 0;
        arr_fault_bit = 0;
        mem_rd_q = '0;
        array_q = '0;
        for (int a = 0; a < `BIST_ARRAY_SIZE; a++) begin
            for (int i = 0; i < LANES; i++) begin
                mem[a][i] = array_data_pkg::psum_t'(a * LANES + i); // address-tagged fill
            end
        end
        for (int p = 0; p < `BIST_SA_DEPTH; p++) begin
            envm_w_tab[p] = array_data_pkg::weight_t'($urandom);
            envm_a_tab[p] = array_data_pkg::act_t'($urandom);
            envm_p_tab[p] = array_data_pkg::psum_t'($urandom_range(16'hffff));
            envm_ans_tab[p] = mac(envm_w_tab[p], envm_a_tab[p], envm_p_tab[p]);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_result("test_done after reset", test_done, 1'b0);
        check_mask("fail_lanes after reset", fail_lanes, '0);

        run_test("mbist fault-free", bist_ctrl_pkg::mode_mbist, 193);

        mem_fault_en = 1'b1;
        mem_fault_lane = $urandom_range(LANES - 1);
        mem_fault_bit = $urandom_range(`BIST_PSUM_W - 1);
        run_test("mbist stuck lane", bist_ctrl_pkg::mode_mbist, 193);
        mem_fault_en = 1'b0;

        run_test("lbist fault-free", bist_ctrl_pkg::mode_lbist, 37);

        arr_fault_en = 1'b1;
        arr_fault_lane = $urandom_range(LANES - 1);
        arr_fault_bit = $urandom_range(`BIST_PSUM_W - 1);
        run_test("lbist stuck lane", bist_ctrl_pkg::mode_lbist, 37);
        arr_fault_en = 1'b0;

        // sticky mask from the lbist run must clear on this start
        run_test("mbist after lbist", bist_ctrl_pkg::mode_mbist, 193);

        $display("tests: %0d, checks: %0d, errors: %0d", test_index, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: hybrid_bist.f
+incdir+verilog
verilog/bist_ctrl_pkg.sv
verilog/array_data_pkg.sv
verilog/bist_fsm.sv
verilog/bist_sequencer.sv
verilog/mbist_pattern_gen.sv
verilog/result_comparator.sv
verilog/hybrid_bist.sv
test/tb_clock_gen.sv
test/hybrid_bist_checker.sv
test/tb_hybrid_bist.sv

// File: Bender.yml
package:
  name: hybrid_bist

export_include_dirs:
  - verilog

sources:
  # packages first, then the RTL bottom-up
  - include_dirs:
      - verilog
    files:
      - verilog/bist_ctrl_pkg.sv
      - verilog/array_data_pkg.sv
      - verilog/bist_fsm.sv
      - verilog/bist_sequencer.sv
      - verilog/mbist_pattern_gen.sv
      - verilog/result_comparator.sv
      - verilog/hybrid_bist.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_clock_gen.sv
      - test/hybrid_bist_checker.sv
      - test/tb_hybrid_bist.sv
